/* filelist.f */
logic/stride_pkg.sv
logic/loop_counter.sv
logic/burst_reader.sv
logic/beat_fifo.sv
logic/stride_regs.sv
logic/stride_reader_top.sv
verification/clock_gen.sv
verification/tb_stride_reader.sv

/* Makefile */
TOP  := tb_stride_reader
SRCS := $(shell grep -v '^+' filelist.f)

obj_dir/V$(TOP): filelist.f $(SRCS)
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

.PHONY: run clean

/* verification/tb_stride_reader.sv */
`timescale 1ns/1ps

module tb_stride_reader;
   import stride_pkg::*;

   logic              clk_i;
   logic              rst_i;
   logic [ADDR_W-1:0] s_awaddr_i, s_araddr_i;
   logic [DATA_W-1:0] s_wdata_i;
   logic [STRB_W-1:0] s_wstrb_i;
   logic              s_awvalid_i, s_wvalid_i, s_bready_i, s_arvalid_i, s_rready_i;
   logic              s_awready_o, s_wready_o, s_bvalid_o, s_arready_o, s_rvalid_o;
   logic [1:0]        s_bresp_o, s_rresp_o;
   logic [DATA_W-1:0] s_rdata_o;
   bus_req_t          bus_req_o;
   bus_rsp_t          bus_rsp_i = '0;
   logic              m_valid_o;
   logic              m_ready_i = 1'b0;
   beat_t             m_data_o;

   integer      seed       = 32'h8ae051a9;
   int unsigned beat_idx   = 0;  // memory side, beat within the open burst.
   logic        bus_moved  = 1'b0;
   int unsigned beat_count = 0;  // stream beats taken so far.
   int unsigned mismatches = 0;
   int unsigned errors, timeouts, run_first, run_len;
   logic [31:0] run_start, run_stride, st;
   logic        heavy;

   clock_gen clk0 (.clk_o(clk_i), .rst_o(rst_i));

   stride_reader_top dut0 (.*);

   function automatic logic [31:0] expected_word(input int unsigned k, input int unsigned j);
      return (run_start + k * run_stride + 4 * j) ^ 32'hA5A5_0000;
   endfunction

   // memory model, then stream sink and checker, in one falling-edge process.
   always @(negedge clk_i) begin : bus_and_stream
      logic [31:0] want;
      int unsigned n;
      if (bus_moved) begin
         beat_idx = bus_rsp_i.last ? 0 : beat_idx + 1;
      end
      bus_rsp_i.ready = (($random(seed) & 3) != 0);
      bus_rsp_i.rdata = (bus_req_o.addr + 4 * beat_idx) ^ 32'hA5A5_0000;
      bus_rsp_i.last  = (beat_idx == 32'(bus_req_o.len));
      bus_moved       = bus_req_o.valid && bus_rsp_i.ready;
      m_ready_i = heavy ? (($random(seed) & 1) != 0) : (($random(seed) & 3) != 0);
      if (m_valid_o && m_ready_i) begin
         n    = beat_count - run_first;
         want = expected_word(n / (run_len + 1), n % (run_len + 1));
         assert (m_data_o.data == want) else begin
            mismatches++;
            $display("FAIL t=%0t m_data_o expected %h actual %h", $time, want, m_data_o.data);
         end
         beat_count++;  // taken at the next rising edge.
      end
   end

   task automatic check_eq(input string what, input logic [31:0] want, input logic [31:0] got);
      assert (got == want) else begin
         errors++;
         $display("FAIL t=%0t %s expected %h actual %h", $time, what, want, got);
      end
   endtask

   task automatic check_wait(input string what, input logic ok);
      assert (ok) else begin
         timeouts++;
         $display("gave up at %0t waiting for %s", $time, what);
      end
   endtask

   task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
      int unsigned left;
      left = 64;
      @(negedge clk_i);
      s_awaddr_i  = addr;
      s_wdata_i   = data;
      s_wstrb_i   = strb;
      s_awvalid_i = 1'b1;
      s_wvalid_i  = 1'b1;
      @(posedge clk_i);
      check_eq("s_awready_o", 32'h1, {31'd0, s_awready_o});
      check_eq("s_wready_o", 32'h1, {31'd0, s_wready_o});
      @(negedge clk_i);
      while (!s_bvalid_o && left != 0) begin
         @(negedge clk_i);
         left--;
      end
      check_wait("write response", s_bvalid_o);
      check_eq("s_bresp_o", 32'(RESP_OKAY), 32'(s_bresp_o));
      s_awvalid_i = 1'b0;
      s_wvalid_i  = 1'b0;
   endtask

   task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
      int unsigned left;
      left = 64;
      @(negedge clk_i);
      s_araddr_i  = addr;
      s_arvalid_i = 1'b1;
      @(posedge clk_i);
      check_eq("s_arready_o", 32'h1, {31'd0, s_arready_o});
      @(negedge clk_i);
      while (!s_rvalid_o && left != 0) begin
         @(negedge clk_i);
         left--;
      end
      check_wait("read data", s_rvalid_o);
      check_eq("s_rresp_o", 32'(RESP_OKAY), 32'(s_rresp_o));
      data        = s_rdata_o;
      s_arvalid_i = 1'b0;
   endtask

   task automatic expect_reg(input logic [31:0] addr, input string what,
                             input logic [31:0] want);
      logic [31:0] got;
      read_reg(addr, got);
      check_eq(what, want, got);
   endtask

   task automatic start_job(input logic [31:0] start, input logic [31:0] stride,
                            input logic [31:0] count, input logic [31:0] len);
      write_reg(REG_START, start, 4'hF);
      write_reg(REG_STRIDE, stride, 4'hF);
      write_reg(REG_COUNT, count, 4'hF);
      write_reg(REG_LEN, len, 4'hF);
      run_start  = start;
      run_stride = stride;
      run_len    = len;
      run_first  = beat_count;  // stream is empty here.
      write_reg(REG_CTRL, 32'h1, 4'h1);
   endtask

   task automatic finish_job(input int unsigned total);
      int unsigned left;
      logic [31:0] status;
      left   = 400;
      status = 32'h1;
      while (status != 32'h2 && left != 0) begin
         read_reg(REG_STATUS, status);
         left--;
      end
      check_wait("done flag", status == 32'h2);
      left = 4000;
      @(posedge clk_i);
      while (beat_count - run_first < total && left != 0) begin
         @(posedge clk_i);
         left--;
      end
      check_wait("stream beats", beat_count - run_first >= total);
      check_eq("beat total", total, beat_count - run_first);
      @(negedge clk_i);
      check_eq("m_valid_o", 32'h0, {31'd0, m_valid_o});
   endtask

   initial begin
      int unsigned left;
      errors      = 0;
      timeouts    = 0;
      run_first   = 0;
      run_len     = 0;
      run_start   = '0;
      run_stride  = '0;
      heavy       = 1'b0;
      s_awaddr_i  = '0;
      s_araddr_i  = '0;
      s_wdata_i   = '0;
      s_wstrb_i   = '0;
      s_awvalid_i = 1'b0;
      s_wvalid_i  = 1'b0;
      s_arvalid_i = 1'b0;
      s_bready_i  = 1'b1;
      s_rready_i  = 1'b1;
      left = 20;
      @(posedge clk_i);
      while (rst_i && left != 0) begin
         @(posedge clk_i);
         left--;
      end
      check_wait("reset release", !rst_i);
      @(negedge clk_i);
      check_eq("idle outputs", 32'h0,
               {28'd0, bus_req_o.valid, m_valid_o, s_bvalid_o, s_rvalid_o});
      for (int a = 0; a <= 32'h14; a += 4) begin
         expect_reg(a, "reset readback", 32'h0);
      end
      write_reg(REG_START, 32'h1234_5678, 4'hF);
      write_reg(REG_STRIDE, 32'hFFFF_FFFF, 4'b0101);
      write_reg(REG_COUNT, 32'hABCD_1234, 4'b0010);
      write_reg(REG_LEN, 32'h0000_01FF, 4'b0001);
      expect_reg(REG_START, "REG_START", 32'h1234_5678);
      expect_reg(REG_STRIDE, "REG_STRIDE", 32'h00FF_00FF);
      expect_reg(REG_COUNT, "REG_COUNT", 32'h0000_1200);
      expect_reg(REG_LEN, "REG_LEN", 32'h0000_00FF);
      start_job(32'h0000_1000, 32'h40, 3, 3);
      finish_job(12);
      heavy = 1'b1;  // sink stalls about half the time.
      start_job(32'h2000_0100, 32'h100, 5, 7);
      finish_job(40);
      heavy = 1'b0;
      start_job(32'h0000_3000, 32'h10, 0, 2);
      finish_job(0);
      start_job(32'h0000_4000, 32'h20, 1, 5);
      finish_job(6);
      // second start lands while busy.
      start_job(32'h0000_5000, 32'h80, 4, 3);
      write_reg(REG_COUNT, 32'h9, 4'hF);
      write_reg(REG_CTRL, 32'h1, 4'h1);
      finish_job(16);
      expect_reg(REG_STATUS, "REG_STATUS", 32'h2);
      start_job(32'h0000_6000, 32'h8, 2, 1);
      read_reg(REG_STATUS, st);
      check_eq("done after restart", 32'h0, {31'd0, st[1]});
      finish_job(4);
      $display("counts: %0d register errors, %0d data mismatches, %0d timeouts",
               errors, mismatches, timeouts);
      if (errors == 0 && mismatches == 0 && timeouts == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* verification/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever begin
         #50 clk_o = ~clk_o;  // 100 ns period.
      end
   end

   initial begin
      rst_o = 1'b1;
      repeat (3) @(posedge clk_o);
      @(negedge clk_o);
      rst_o = 1'b0;  // released between edges.
   end

endmodule

/* logic/stride_reader_top.sv */
`timescale 1ns/1ps

module stride_reader_top (
   input  logic                          clk_i,
   input  logic                          rst_i,
   input  logic [stride_pkg::ADDR_W-1:0] s_awaddr_i,
   input  logic                          s_awvalid_i,
   output logic                          s_awready_o,
   input  logic [stride_pkg::DATA_W-1:0] s_wdata_i,
   input  logic [stride_pkg::STRB_W-1:0] s_wstrb_i,
   input  logic                          s_wvalid_i,
   output logic                          s_wready_o,
   output logic [1:0]                    s_bresp_o,
   output logic                          s_bvalid_o,
   input  logic                          s_bready_i,
   input  logic [stride_pkg::ADDR_W-1:0] s_araddr_i,
   input  logic                          s_arvalid_i,
   output logic                          s_arready_o,
   output logic [stride_pkg::DATA_W-1:0] s_rdata_o,
   output logic [1:0]                    s_rresp_o,
   output logic                          s_rvalid_o,
   input  logic                          s_rready_i,
   output stride_pkg::bus_req_t          bus_req_o,
   input  stride_pkg::bus_rsp_t          bus_rsp_i,
   output logic                          m_valid_o,
   input  logic                          m_ready_i,
   output stride_pkg::beat_t             m_data_o
);
   import stride_pkg::*;

   read_cfg_t cfg;
   beat_t     beat;
   logic      start;
   logic      finished;
   logic      beat_valid;
   logic      room;

   stride_regs u_regs (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .s_awaddr_i  (s_awaddr_i),
      .s_awvalid_i (s_awvalid_i),
      .s_awready_o (s_awready_o),
      .s_wdata_i   (s_wdata_i),
      .s_wstrb_i   (s_wstrb_i),
      .s_wvalid_i  (s_wvalid_i),
      .s_wready_o  (s_wready_o),
      .s_bresp_o   (s_bresp_o),
      .s_bvalid_o  (s_bvalid_o),
      .s_bready_i  (s_bready_i),
      .s_araddr_i  (s_araddr_i),
      .s_arvalid_i (s_arvalid_i),
      .s_arready_o (s_arready_o),
      .s_rdata_o   (s_rdata_o),
      .s_rresp_o   (s_rresp_o),
      .s_rvalid_o  (s_rvalid_o),
      .s_rready_i  (s_rready_i),
      .cfg_o       (cfg),
      .start_o     (start),
      .finished_i  (finished)
   );

   burst_reader u_reader (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .cfg_i        (cfg),
      .start_i      (start),
      .req_o        (bus_req_o),
      .rsp_i        (bus_rsp_i),
      .room_i       (room),
      .beat_o       (beat),
      .beat_valid_o (beat_valid),
      .finished_o   (finished)
   );

   beat_fifo u_fifo (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .wr_valid_i (beat_valid),
      .wr_data_i  (beat),
      .room_o     (room),
      .rd_valid_o (m_valid_o),
      .rd_ready_i (m_ready_i),
      .rd_data_o  (m_data_o)
   );

endmodule

/* logic/stride_regs.sv */
`timescale 1ns/1ps

module stride_regs (
   input  logic                             clk_i,
   input  logic                             rst_i,
   input  logic [stride_pkg::ADDR_W-1:0]    s_awaddr_i,
   input  logic                             s_awvalid_i,
   output logic                             s_awready_o,
   input  logic [stride_pkg::DATA_W-1:0]    s_wdata_i,
   input  logic [stride_pkg::STRB_W-1:0]    s_wstrb_i,
   input  logic                             s_wvalid_i,
   output logic                             s_wready_o,
   output logic [1:0]                       s_bresp_o,
   output logic                             s_bvalid_o,
   input  logic                             s_bready_i,
   input  logic [stride_pkg::ADDR_W-1:0]    s_araddr_i,
   input  logic                             s_arvalid_i,
   output logic                             s_arready_o,
   output logic [stride_pkg::DATA_W-1:0]    s_rdata_o,
   output logic [1:0]                       s_rresp_o,
   output logic                             s_rvalid_o,
   input  logic                             s_rready_i,
   output stride_pkg::read_cfg_t            cfg_o,
   output logic                             start_o,
   input  logic                             finished_i
);
   import stride_pkg::*;

   logic              busy_q;
   logic              done_q;
   logic              wr_fire;
   logic              go;
   logic [DATA_W-1:0] wr_merged;

   function automatic logic [DATA_W-1:0] reg_value(input logic [ADDR_W-1:0] offs);
      logic [DATA_W-1:0] v;
      v = '0;
      case (offs)
         REG_STATUS: v[1:0] = {done_q, busy_q};
         REG_START:  v = cfg_o.start_addr;
         REG_STRIDE: v = cfg_o.stride;
         REG_COUNT:  v[COUNT_W-1:0] = cfg_o.count;
         REG_LEN:    v[LEN_W-1:0] = cfg_o.len;
         default:    v = '0;  // ctrl and holes read zero.
      endcase
      return v;
   endfunction

   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_v,
                                                     input logic [DATA_W-1:0] new_v,
                                                     input logic [STRB_W-1:0] strb);
      logic [DATA_W-1:0] v;
      v = old_v;
      for (int b = 0; b < STRB_W; b++) begin
         if (strb[b]) begin
            v[8*b +: 8] = new_v[8*b +: 8];
         end
      end
      return v;
   endfunction

   // aw and w are taken together, one write at a time.
   assign wr_fire     = s_awvalid_i && s_wvalid_i && !s_bvalid_o;
   assign s_awready_o = wr_fire;
   assign s_wready_o  = wr_fire;
   assign s_bresp_o   = RESP_OKAY;
   assign wr_merged   = merge_bytes(reg_value(s_awaddr_i), s_wdata_i, s_wstrb_i);

   assign go = wr_fire && (s_awaddr_i == REG_CTRL) && s_wstrb_i[0] && s_wdata_i[0] &&
               !busy_q && !start_o;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         cfg_o      <= '0;
         s_bvalid_o <= 1'b0;
         start_o    <= 1'b0;
         busy_q     <= 1'b0;
         done_q     <= 1'b0;
      end else begin
         start_o <= go;
         if (wr_fire) begin
            s_bvalid_o <= 1'b1;
            case (s_awaddr_i)
               REG_START:  cfg_o.start_addr <= wr_merged;
               REG_STRIDE: cfg_o.stride     <= wr_merged;
               REG_COUNT:  cfg_o.count      <= wr_merged[COUNT_W-1:0];
               REG_LEN:    cfg_o.len        <= wr_merged[LEN_W-1:0];
               default:    ;
            endcase
         end else if (s_bready_i) begin
            s_bvalid_o <= 1'b0;
         end
         if (start_o) begin
            busy_q <= 1'b1;
         end else if (finished_i) begin
            busy_q <= 1'b0;
         end
         if (go) begin
            done_q <= 1'b0;  // a fresh run clears done.
         end else if (finished_i) begin
            done_q <= 1'b1;
         end
      end
   end

   assign s_arready_o = !s_rvalid_o;
   assign s_rresp_o   = RESP_OKAY;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         s_rvalid_o <= 1'b0;
      end else if (s_arvalid_i && s_arready_o) begin
         s_rvalid_o <= 1'b1;
      end else if (s_rready_i) begin
         s_rvalid_o <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (s_arvalid_i && s_arready_o) begin
         s_rdata_o <= reg_value(s_araddr_i);
      end
   end

   // sequencer only finishes a run that was started.
   a_finish_busy: assert property (@(posedge clk_i) disable iff (rst_i)
      finished_i |-> busy_q);

endmodule

/* logic/beat_fifo.sv */
`timescale 1ns/1ps

module beat_fifo (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              wr_valid_i,
   input  stride_pkg::beat_t wr_data_i,
   output logic              room_o,
   output logic              rd_valid_o,
   input  logic              rd_ready_i,
   output stride_pkg::beat_t rd_data_o
);
   import stride_pkg::*;

   beat_t                 mem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr;
   logic [FIFO_PTR_W-1:0] rd_ptr;
   logic [FIFO_CNT_W-1:0] used;
   logic                  push;
   logic                  pop;

   assign room_o     = (used != FIFO_CNT_W'(FIFO_DEPTH));
   assign rd_valid_o = (used != '0);
   assign rd_data_o  = mem[rd_ptr];
   assign push       = wr_valid_i && room_o;
   assign pop        = rd_valid_o && rd_ready_i;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         used   <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   used <= used + 1'b1;
            2'b01:   used <= used - 1'b1;
            default: used <= used;  // both or neither.
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (push) begin
         mem[wr_ptr] <= wr_data_i;
      end
   end

   // upstream must hold off on a full fifo.
   a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
      wr_valid_i |-> room_o);

endmodule

/* logic/burst_reader.sv */
`timescale 1ns/1ps

module burst_reader (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  stride_pkg::read_cfg_t cfg_i,
   input  logic                  start_i,
   output stride_pkg::bus_req_t  req_o,
   input  stride_pkg::bus_rsp_t  rsp_i,
   input  logic                  room_i,
   output stride_pkg::beat_t     beat_o,
   output logic                  beat_valid_o,
   output logic                  finished_o
);
   import stride_pkg::*;

   typedef enum logic [1:0] {
      S_IDLE  = 2'b00,
      S_CHECK = 2'b01,
      S_BURST = 2'b10
   } state_t;

   state_t            state;
   logic [ADDR_W-1:0] addr;
   logic [ADDR_W-1:0] stride;
   logic [LEN_W-1:0]  len;
   logic              take;
   logic              beat;
   logic              last_beat;
   logic              is_zero;

   assign take      = (state == S_IDLE) && start_i;
   assign beat      = req_o.valid && rsp_i.ready;
   assign last_beat = beat && rsp_i.last;

   loop_counter u_loop_counter (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .load_i    (take),
      .count_i   (cfg_i.count),
      .advance_i (last_beat),
      .is_zero_o (is_zero)
   );

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state <= S_IDLE;
      end else begin
         case (state)
            S_IDLE: begin
               if (take) begin
                  state <= S_CHECK;
               end
            end
            S_CHECK: begin
               if (is_zero) begin
                  state <= S_IDLE;
               end else begin
                  state <= S_BURST;
               end
            end
            S_BURST: begin
               if (last_beat) begin
                  state <= S_CHECK;  // recheck count before next burst.
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // run parameters, latched once per start.
   always_ff @(posedge clk_i) begin
      if (take) begin
         addr   <= cfg_i.start_addr;
         stride <= cfg_i.stride;
         len    <= cfg_i.len;
      end else if (last_beat) begin
         addr <= addr + stride;
      end
   end

   assign req_o.valid  = (state == S_BURST) && room_i;  // pause when fifo full.
   assign req_o.addr   = addr;
   assign req_o.len    = len;
   assign beat_o.data  = rsp_i.rdata;
   assign beat_valid_o = beat;
   assign finished_o   = (state == S_CHECK) && is_zero;

   // a start only arrives while no run is open.
   a_start_idle: assert property (@(posedge clk_i) disable iff (rst_i)
      start_i |-> (state == S_IDLE));

endmodule

/* logic/loop_counter.sv */
`timescale 1ns/1ps

module loop_counter (
   input  logic                           clk_i,
   input  logic                           rst_i,
   input  logic                           load_i,
   input  logic [stride_pkg::COUNT_W-1:0] count_i,
   input  logic                           advance_i,
   output logic                           is_zero_o
);
   import stride_pkg::*;

   logic [COUNT_W-1:0] remain;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         remain <= '0;
      end else if (load_i) begin
         remain <= count_i;
      end else if (advance_i && (remain != '0)) begin
         remain <= remain - 1'b1;  // one burst done.
      end
   end

   assign is_zero_o = (remain == '0);

   // sequencer must not open a burst past the programmed count.
   a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
      advance_i |-> !is_zero_o);

endmodule

/* logic/stride_pkg.sv */
package stride_pkg;

   localparam int ADDR_W  = 32;
   localparam int DATA_W  = 32;
   localparam int LEN_W   = 8;   // beats minus one.
   localparam int COUNT_W = 16;
   localparam int STRB_W  = DATA_W / 8;

   localparam int FIFO_DEPTH = 8;
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
   localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

   localparam logic [1:0] RESP_OKAY = 2'b00;

   // host register map.
   localparam logic [ADDR_W-1:0] REG_CTRL   = 32'h00;  // bit 0 start.
   localparam logic [ADDR_W-1:0] REG_STATUS = 32'h04;  // bit 0 busy, bit 1 done.
   localparam logic [ADDR_W-1:0] REG_START  = 32'h08;
   localparam logic [ADDR_W-1:0] REG_STRIDE = 32'h0C;
   localparam logic [ADDR_W-1:0] REG_COUNT  = 32'h10;
   localparam logic [ADDR_W-1:0] REG_LEN    = 32'h14;

   typedef struct packed {
      logic [ADDR_W-1:0]  start_addr;
      logic [ADDR_W-1:0]  stride;
      logic [COUNT_W-1:0] count;
      logic [LEN_W-1:0]   len;
   } read_cfg_t;

   // read request toward memory.
   typedef struct packed {
      logic              valid;
      logic [ADDR_W-1:0] addr;
      logic [LEN_W-1:0]  len;
   } bus_req_t;

   typedef struct packed {
      logic              ready;
      logic [DATA_W-1:0] rdata;
      logic              last;
   } bus_rsp_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
   } beat_t;

endpackage
